// File: sources.f
+incdir+common
common/video_pkg.sv
common/video_if.sv
hw/bus_decoder.sv
video/video_regs.sv
video/frame_buffer.sv
video/pixel_scanner.sv
video/pixel_colorizer.sv
hw/video_frame_top.sv
tests/tb_clock_gen.sv
tests/video_frame_properties.sv
tests/tb_video_frame.sv

// File: Bender.yml
package:
  name: video_frame

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/video_pkg.sv
      - common/video_if.sv
      - hw/bus_decoder.sv
      - video/video_regs.sv
      - video/frame_buffer.sv
      - video/pixel_scanner.sv
      - video/pixel_colorizer.sv
      - hw/video_frame_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_clock_gen.sv
      - tests/video_frame_properties.sv
      - tests/tb_video_frame.sv

// File: tests/tb_video_frame.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defines.svh"

module tb_video_frame;
	import video_pkg::*;

	localparam int num_tests       = 6;
	localparam int cycles_per_test = 5000;
	localparam int clk_period_ns   = 40;

	logic        Clock25Mhz;
	logic        rst_n;
	logic        as_l;
	logic        lds_l;
	logic        rw;
	logic [31:0] address;
	logic [7:0]  wdata;
	logic        pix_credit;
	logic [7:0]  rdata;
	logic        dtack_l;
	logic        berr_l;
	logic        pix_valid;
	logic        pix_first;
	colour_t     pix_colour;

	logic [7:0]  fb_model [0:(1 << `FB_ADDR_W)-1];     // bytes written over the bus
	colour_t     fg_model;
	colour_t     bg_model;
	int          errors;
	int          checks;
	int          tests_run;
	int          test_start_errors;

	tb_clock_gen i_clock_gen (
		.Clock25Mhz (Clock25Mhz),
		.rst_n      (rst_n)
	);

	video_frame_top i_video_frame_top (
		.Clock25Mhz (Clock25Mhz),
		.rst_n      (rst_n),
		.as_l       (as_l),
		.lds_l      (lds_l),
		.rw         (rw),
		.address    (address),
		.wdata      (wdata),
		.pix_credit (pix_credit),
		.rdata      (rdata),
		.dtack_l    (dtack_l),
		.berr_l     (berr_l),
		.pix_valid  (pix_valid),
		.pix_first  (pix_first),
		.pix_colour (pix_colour)
	);

	// handshake checks on the decoder, credit checks on the scanner
	bind bus_decoder video_frame_properties i_decoder_props (
		.Clock25Mhz (Clock25Mhz),
		.rst_n      (rst_n),
		.dtack_l    (dtack_l),
		.berr_l     (berr_l),
		.issue      (1'b0),
		.pix_credit (1'b0),
		.credit_cnt ('0)
	);

	bind pixel_scanner video_frame_properties i_scanner_props (
		.Clock25Mhz (Clock25Mhz),
		.rst_n      (rst_n),
		.dtack_l    (1'b1),
		.berr_l     (1'b1),
		.issue      (issue),
		.pix_credit (pix_credit),
		.credit_cnt (credit_cnt)
	);

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic check_colour(input string name, input colour_t got, input colour_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		tests_run++;
		$display("test %-12s %s (%0d errors)", name,
		         (errors == test_start_errors) ? "ok" : "failed", errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// raster order, bit 0 of each byte is the leftmost pixel
	function automatic colour_t expected_colour(input int idx);
		int         x;
		int         y;
		logic [7:0] pix_byte;
		x        = idx % `SCREEN_W;
		y        = idx / `SCREEN_W;
		pix_byte = fb_model[y * `BYTES_PER_ROW + x / 8];
		return pix_byte[x % 8] ? fg_model : bg_model;
	endfunction

	task automatic bus_cycle(input logic [31:0] addr, input logic read, input logic lds,
	                         input logic [7:0] wd, output logic [7:0] rd_data,
	                         output logic dtack_seen, output logic berr_seen);
		int waited;
		waited = 0;
		@(negedge Clock25Mhz);
		address = addr;
		rw      = read;
		lds_l   = lds;
		wdata   = wd;
		as_l    = 1'b0;
		do
		begin
			@(negedge Clock25Mhz);
			waited++;
		end
		while (dtack_l && berr_l && waited < 16);
		rd_data    = rdata;
		dtack_seen = dtack_l;
		berr_seen  = berr_l;
		if (dtack_l && berr_l)
		begin
			errors++;
			$display("bus cycle to 0x%08h got neither dtack nor bus error", addr);
		end
		as_l  = 1'b1;
		lds_l = 1'b1;
		@(negedge Clock25Mhz);
		if (!dtack_l || !berr_l)
		begin
			errors++;
			$display("bus handshake to 0x%08h not released after as_l rose", addr);
		end
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [7:0] data);
		logic [7:0] rd_ignored;
		logic       dtack_seen;
		logic       berr_seen;
		bus_cycle(addr, 1'b0, 1'b0, data, rd_ignored, dtack_seen, berr_seen);
		if (dtack_seen)
		begin
			errors++;
			$display("write to 0x%08h was not acknowledged", addr);
		end
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [7:0] data);
		logic dtack_seen;
		logic berr_seen;
		bus_cycle(addr, 1'b1, 1'b0, 8'h00, data, dtack_seen, berr_seen);
		if (dtack_seen)
		begin
			errors++;
			$display("read from 0x%08h was not acknowledged", addr);
		end
	endtask

	// one credit back for each pixel when give_credit is set
	task automatic receive_pixels(input int first_idx, input int count,
	                              input bit give_credit, input bit check_en);
		int got;
		int waited;
		int limit;
		got    = 0;
		waited = 0;
		limit  = count * 8 + 64;
		while (got < count && waited < limit)
		begin
			@(negedge Clock25Mhz);
			pix_credit = 1'b0;
			waited++;
			if (pix_valid)
			begin
				if (check_en)
				begin
					check_colour("pix_colour", pix_colour, expected_colour(first_idx + got));
					check_bit("pix_first", pix_first, (first_idx + got) == 0);
				end
				pix_credit = give_credit;
				got++;
			end
		end
		if (got < count)
		begin
			errors++;
			$display("timeout: %0d of %0d pixels arrived from pixel %0d", got, count, first_idx);
		end
	endtask

	task automatic expect_no_pixels(input int cycles);
		repeat (cycles)
		begin
			@(negedge Clock25Mhz);
			pix_credit = 1'b0;
			check_bit("pix_valid", pix_valid, 1'b0);
		end
	endtask

	task automatic return_credits(input int count);
		repeat (count)
		begin
			@(negedge Clock25Mhz);
			pix_credit = 1'b1;
		end
		@(negedge Clock25Mhz);
		pix_credit = 1'b0;
	endtask

	task automatic test_reset();
		check_bit("dtack_l", dtack_l, 1'b1);
		check_bit("berr_l", berr_l, 1'b1);
		expect_no_pixels(10);
		report_test("reset");
	endtask

	task automatic test_registers();
		logic [7:0] value;
		bus_write(`REG_BASE + `REG_CTRL, 8'hFE);
		bus_read(`REG_BASE + `REG_CTRL, value);
		check_byte("ctrl", value, 8'h00);     // only bit 0 is stored
		fg_model = colour_t'($urandom);
		bus_write(`REG_BASE + `REG_FG, fg_model);
		bus_read(`REG_BASE + `REG_FG, value);
		check_colour("fg_colour", value, fg_model);
		bg_model = colour_t'($urandom);
		bus_write(`REG_BASE + `REG_BG, bg_model);
		bus_read(`REG_BASE + `REG_BG, value);
		check_colour("bg_colour", value, bg_model);
		report_test("registers");
	endtask

	task automatic test_fb_access();
		fb_addr_t   addrs [20];
		logic [7:0] value;
		foreach (addrs[i])
		begin
			addrs[i]           = fb_addr_t'($urandom);
			value              = 8'($urandom);
			fb_model[addrs[i]] = value;
			bus_write(`FB_BASE + addrs[i], value);
		end
		foreach (addrs[i])
		begin
			bus_read(`FB_BASE + addrs[i], value);
			check_byte("rdata", value, fb_model[addrs[i]]);     // repeats keep the last write
		end
		report_test("fb_access");
	endtask

	task automatic test_bus_error();
		logic [7:0] value;
		logic       dtack_seen;
		logic       berr_seen;
		bus_cycle(32'h0020_0000, 1'b1, 1'b0, 8'h00, value, dtack_seen, berr_seen);
		check_bit("berr_l", berr_seen, 1'b0);
		check_bit("dtack_l", dtack_seen, 1'b1);
		bus_cycle(`FB_BASE + 32'h10, 1'b1, 1'b1, 8'h00, value, dtack_seen, berr_seen);
		check_bit("berr_l", berr_seen, 1'b0);     // upper lane only
		check_bit("dtack_l", dtack_seen, 1'b1);
		report_test("bus_error");
	endtask

	task automatic test_streaming();
		logic [7:0] value;
		for (int i = 0; i < 2 * `BYTES_PER_ROW; i++)
		begin
			value       = 8'($urandom);
			fb_model[i] = value;
			bus_write(`FB_BASE + i, value);
		end
		fg_model = colour_t'($urandom);
		bg_model = ~fg_model;
		bus_write(`REG_BASE + `REG_FG, fg_model);
		bus_write(`REG_BASE + `REG_BG, bg_model);
		bus_write(`REG_BASE + `REG_CTRL, 8'h01);
		receive_pixels(0, 2 * `SCREEN_W, 1'b1, 1'b1);
		receive_pixels(2 * `SCREEN_W, `CREDIT_DEPTH, 1'b0, 1'b0);     // row 2 not filled
		bus_write(`REG_BASE + `REG_CTRL, 8'h00);
		return_credits(`CREDIT_DEPTH);
		report_test("streaming");
	endtask

	task automatic test_backpressure();
		logic [7:0] value;
		fg_model = colour_t'($urandom);
		bg_model = fg_model ^ 8'h3C;
		bus_write(`REG_BASE + `REG_FG, fg_model);
		bus_write(`REG_BASE + `REG_BG, bg_model);
		bus_write(`REG_BASE + `REG_CTRL, 8'h01);     // raster restarts at (0,0)
		receive_pixels(0, `CREDIT_DEPTH, 1'b0, 1'b1);
		expect_no_pixels(30);
		bus_read(`REG_BASE + `REG_CTRL, value);      // scanner is stalled, no pixels to miss
		check_byte("ctrl", value, 8'h01);
		return_credits(1);
		receive_pixels(`CREDIT_DEPTH, 60, 1'b1, 1'b1);
		report_test("backpressure");
	endtask

	initial
	begin
		#(num_tests * cycles_per_test * clk_period_ns);
		$display("watchdog expired after %0d cycles", num_tests * cycles_per_test);
		$display("*** FAILED ***");
		$finish;
	end

	initial
	begin
		void'($urandom(26215));
		as_l       = 1'b1;
		lds_l      = 1'b1;
		rw         = 1'b1;
		address    = '0;
		wdata      = '0;
		pix_credit = 1'b0;
		@(posedge rst_n);
		test_reset();
		test_registers();
		test_fb_access();
		test_bus_error();
		test_streaming();
		test_backpressure();
		errors += i_video_frame_top.i_bus_decoder.i_decoder_props.fail_count;
		errors += i_video_frame_top.i_pixel_scanner.i_scanner_props.fail_count;
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/video_frame_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defines.svh"

module video_frame_properties (
	input wire                                   Clock25Mhz,
	input wire                                   rst_n,
	input wire                                   dtack_l,
	input wire                                   berr_l,
	input wire                                   issue,
	input wire                                   pix_credit,
	input wire [$clog2(`CREDIT_DEPTH + 1)-1:0]   credit_cnt
);
	int fail_count = 0;     // read by the testbench at the end of the run

	handshake_exclusive: assert property (@(posedge Clock25Mhz) disable iff (!rst_n)
		!(!dtack_l && !berr_l))
	else
	begin
		fail_count++;
		$error("dtack_l and berr_l low in the same cycle");
	end

	// spending the last credit with none coming back must stall the next cycle
	no_fetch_without_credit: assert property (@(posedge Clock25Mhz) disable iff (!rst_n)
		(issue && (credit_cnt == 1) && !pix_credit) |=> !issue)
	else
	begin
		fail_count++;
		$error("fetch issued with zero credits");
	end

	credit_bounded: assert property (@(posedge Clock25Mhz) disable iff (!rst_n)
		credit_cnt <= `CREDIT_DEPTH)
	else
	begin
		fail_count++;
		$error("credit counter above depth: %0d", credit_cnt);
	end

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic Clock25Mhz,
	output logic rst_n
);
	localparam int half_period_ns = 20;     // 40 ns period
	localparam int reset_cycles   = 5;

	initial
	begin
		Clock25Mhz = 1'b0;
		forever #half_period_ns Clock25Mhz = ~Clock25Mhz;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge Clock25Mhz);
		@(negedge Clock25Mhz);
		rst_n = 1'b1;     // release away from the rising edge
	end

endmodule

`default_nettype wire

// File: hw/video_frame_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_frame_top (
	input  wire                 Clock25Mhz,
	input  wire                 rst_n,
	input  wire                 as_l,
	input  wire                 lds_l,
	input  wire                 rw,
	input  wire  [31:0]         address,
	input  wire  [7:0]          wdata,
	input  wire                 pix_credit,
	output wire  [7:0]          rdata,
	output wire                 dtack_l,
	output wire                 berr_l,
	output wire                 pix_valid,
	output wire                 pix_first,
	output video_pkg::colour_t  pix_colour
);
	import video_pkg::*;

	logic    enable;
	colour_t fg_colour;
	colour_t bg_colour;
	logic    first;       // travels with the fetch of pixel (0,0)

	bus_req_if i_bus_req ();
	fetch_if   i_fetch ();

	bus_decoder i_bus_decoder (
		.Clock25Mhz (Clock25Mhz),
		.rst_n      (rst_n),
		.as_l       (as_l),
		.lds_l      (lds_l),
		.rw         (rw),
		.address    (address),
		.wdata      (wdata),
		.rdata      (rdata),
		.dtack_l    (dtack_l),
		.berr_l     (berr_l),
		.bus        (i_bus_req.decoder)
	);

	video_regs i_video_regs (
		.Clock25Mhz (Clock25Mhz),
		.rst_n      (rst_n),
		.bus        (i_bus_req.regs),
		.enable     (enable),
		.fg_colour  (fg_colour),
		.bg_colour  (bg_colour)
	);

	frame_buffer i_frame_buffer (
		.Clock25Mhz (Clock25Mhz),
		.bus        (i_bus_req.mem),
		.fetch      (i_fetch.mem)
	);

	pixel_scanner i_pixel_scanner (
		.Clock25Mhz (Clock25Mhz),
		.rst_n      (rst_n),
		.enable     (enable),
		.pix_credit (pix_credit),
		.fetch      (i_fetch.scanner),
		.first      (first)
	);

	pixel_colorizer i_pixel_colorizer (
		.Clock25Mhz (Clock25Mhz),
		.rst_n      (rst_n),
		.fetch      (i_fetch.colorizer),
		.first      (first),
		.fg_colour  (fg_colour),
		.bg_colour  (bg_colour),
		.pix_valid  (pix_valid),
		.pix_first  (pix_first),
		.pix_colour (pix_colour)
	);

endmodule

`default_nettype wire

// File: video/pixel_colorizer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_colorizer (
	input  wire                 Clock25Mhz,
	input  wire                 rst_n,
	fetch_if.colorizer          fetch,
	input  wire                 first,
	input  video_pkg::colour_t  fg_colour,
	input  video_pkg::colour_t  bg_colour,
	output logic                pix_valid,
	output logic                pix_first,
	output video_pkg::colour_t  pix_colour
);
	import video_pkg::*;

	logic       valid_q;     // lines up with fetch_data
	logic       first_q;
	logic [2:0] bit_q;

	always_ff @(posedge Clock25Mhz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_q    <= 1'b0;
			first_q    <= 1'b0;
			bit_q      <= '0;
			pix_valid  <= 1'b0;
			pix_first  <= 1'b0;
			pix_colour <= '0;
		end
		else
		begin
			valid_q   <= fetch.fetch_valid;
			first_q   <= first;
			bit_q     <= fetch.fetch_bit;
			pix_valid <= valid_q;
			pix_first <= valid_q && first_q;
			if (valid_q)
				pix_colour <= fetch.fetch_data[bit_q] ? fg_colour : bg_colour;
		end
	end

endmodule

`default_nettype wire

// File: video/pixel_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defines.svh"

module pixel_scanner (
	input  wire       Clock25Mhz,
	input  wire       rst_n,
	input  wire       enable,
	input  wire       pix_credit,
	fetch_if.scanner  fetch,
	output logic      first
);
	import video_pkg::*;

	localparam int credit_w = $clog2(`CREDIT_DEPTH + 1);
	localparam pix_x_t last_x = pix_x_t'(`SCREEN_W - 1);
	localparam pix_y_t last_y = pix_y_t'(`SCREEN_H - 1);

	logic [credit_w-1:0] credit_cnt;
	logic   enable_q;
	logic   restart;
	logic   issue;
	pix_x_t x_cnt;
	pix_y_t y_cnt;
	pix_x_t cur_x;
	pix_y_t cur_y;

	assign restart = enable && !enable_q;     // rising edge of enable
	assign cur_x   = restart ? '0 : x_cnt;
	assign cur_y   = restart ? '0 : y_cnt;
	assign issue   = enable && (credit_cnt != '0);

	assign fetch.fetch_valid = issue;
	assign fetch.fetch_addr  = fb_addr_t'(cur_y) * fb_addr_t'(`BYTES_PER_ROW)
	                         + fb_addr_t'(cur_x[7:3]);
	assign fetch.fetch_bit   = cur_x[2:0];
	assign first             = issue && (cur_x == '0) && (cur_y == '0);

	always_ff @(posedge Clock25Mhz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			credit_cnt <= credit_w'(`CREDIT_DEPTH);   // display side starts full
			enable_q   <= 1'b0;
			x_cnt      <= '0;
			y_cnt      <= '0;
		end
		else
		begin
			enable_q   <= enable;
			credit_cnt <= credit_cnt - credit_w'(issue) + credit_w'(pix_credit);
			if (issue)
			begin
				if (cur_x == last_x)
				begin
					x_cnt <= '0;
					y_cnt <= (cur_y == last_y) ? '0 : cur_y + 8'd1;
				end
				else
				begin
					x_cnt <= cur_x + 8'd1;
					y_cnt <= cur_y;
				end
			end
			else if (restart)
			begin
				x_cnt <= '0;     // no credit yet, still restart the frame
				y_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: video/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defines.svh"

module frame_buffer (
	input  wire     Clock25Mhz,
	bus_req_if.mem  bus,
	fetch_if.mem    fetch
);
	import video_pkg::*;

	localparam int depth = 1 << `FB_ADDR_W;     // 8 KB

	logic [7:0] mem [0:depth-1];
	logic       bus_sel;

	assign bus_sel = (bus.region == REGION_FB);

	// bus port, write and registered read
	always_ff @(posedge Clock25Mhz)
	begin
		if (bus_sel && bus.wr)
			mem[bus.addr] <= bus.wdata;
		if (bus_sel && bus.rd)
			bus.fb_rdata <= mem[bus.addr];
	end

	// fetch port is read only, a same-cycle bus write shows up on the next fetch
	always_ff @(posedge Clock25Mhz)
	begin
		if (fetch.fetch_valid)
			fetch.fetch_data <= mem[fetch.fetch_addr];
	end

endmodule

`default_nettype wire

// File: video/video_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defines.svh"

module video_regs (
	input  wire                 Clock25Mhz,
	input  wire                 rst_n,
	bus_req_if.regs             bus,
	output logic                enable,
	output video_pkg::colour_t  fg_colour,
	output video_pkg::colour_t  bg_colour
);
	import video_pkg::*;

	logic [2:0] reg_off;
	logic       sel;

	assign reg_off = bus.addr[2:0];
	assign sel     = (bus.region == REGION_REG);

	always_ff @(posedge Clock25Mhz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			enable        <= 1'b0;
			fg_colour     <= '0;
			bg_colour     <= '0;
			bus.reg_rdata <= '0;
		end
		else
		begin
			if (sel && bus.wr)
			begin
				case (reg_off)
					3'(`REG_CTRL): enable    <= bus.wdata[0];   // other bits dropped
					3'(`REG_FG):   fg_colour <= bus.wdata;
					3'(`REG_BG):   bg_colour <= bus.wdata;
					default: ;                                  // unused offsets
				endcase
			end
			if (sel && bus.rd)
			begin
				case (reg_off)
					3'(`REG_CTRL): bus.reg_rdata <= {7'b0, enable};
					3'(`REG_FG):   bus.reg_rdata <= fg_colour;
					3'(`REG_BG):   bus.reg_rdata <= bg_colour;
					default:       bus.reg_rdata <= 8'h00;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "video_defines.svh"

module bus_decoder (
	input  wire         Clock25Mhz,
	input  wire         rst_n,
	input  wire         as_l,
	input  wire         lds_l,
	input  wire         rw,
	input  wire  [31:0] address,
	input  wire  [7:0]  wdata,
	output logic [7:0]  rdata,
	output logic        dtack_l,
	output logic        berr_l,
	bus_req_if.decoder  bus
);
	import video_pkg::*;

	localparam logic [31:0] fb_base  = `FB_BASE;
	localparam logic [31:0] reg_base = `REG_BASE;

	bus_state_e state;
	region_e    region_d;

	// address map, only the lower byte lane is wired
	always_comb
	begin
		region_d = REGION_NONE;
		if (!lds_l)
		begin
			if (address[31:`FB_ADDR_W] == fb_base[31:`FB_ADDR_W])
				region_d = REGION_FB;
			else if (address[31:3] == reg_base[31:3])
				region_d = REGION_REG;      // 8 byte window
		end
	end

	always_ff @(posedge Clock25Mhz or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= BUS_IDLE;
			bus.region <= REGION_NONE;
			bus.wr     <= 1'b0;
			bus.rd     <= 1'b0;
			bus.addr   <= '0;
			bus.wdata  <= '0;
			dtack_l    <= 1'b1;
			berr_l     <= 1'b1;
		end
		else
		begin
			bus.wr <= 1'b0;     // strobes last one cycle
			bus.rd <= 1'b0;
			case (state)
				BUS_IDLE:
					if (!as_l)
					begin
						bus.addr   <= fb_addr_t'(address[`FB_ADDR_W-1:0]);
						bus.wdata  <= wdata;
						bus.region <= region_d;
						if (region_d == REGION_NONE)
						begin
							state  <= BUS_ERR;
							berr_l <= 1'b0;     // no strobe for unmapped cycles
						end
						else
						begin
							state  <= BUS_ACCESS;
							bus.wr <= !rw;
							bus.rd <= rw;
						end
					end
				BUS_ACCESS:
				begin
					state   <= BUS_ACK;      // read data lands with this edge
					dtack_l <= 1'b0;
				end
				BUS_ACK, BUS_ERR:
					if (as_l)
					begin
						state   <= BUS_IDLE;
						dtack_l <= 1'b1;
						berr_l  <= 1'b1;
					end
				default: state <= BUS_IDLE;
			endcase
		end
	end

	// both read ports are registered on the rd strobe and hold until the next read
	assign rdata = (state != BUS_ACK)        ? 8'h00 :
	               (bus.region == REGION_FB) ? bus.fb_rdata : bus.reg_rdata;

endmodule

`default_nettype wire

// File: common/video_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded bus cycle, from the bus decoder to the register block and frame buffer
interface bus_req_if;
	import video_pkg::*;

	region_e   region;     // qualifies wr and rd
	logic      wr;         // one cycle write strobe
	logic      rd;         // one cycle read strobe
	fb_addr_t  addr;
	logic [7:0] wdata;
	logic [7:0] reg_rdata;
	logic [7:0] fb_rdata;

	modport decoder (output region, wr, rd, addr, wdata, input reg_rdata, fb_rdata);
	modport regs (input region, wr, rd, addr, wdata, output reg_rdata);
	modport mem (input region, wr, rd, addr, wdata, output fb_rdata);
endinterface

// pixel fetch path, scanner to frame buffer second port to colorizer
interface fetch_if;
	import video_pkg::*;

	logic      fetch_valid;
	fb_addr_t  fetch_addr;
	logic [2:0] fetch_bit;     // pixel inside the byte, 0 is leftmost
	logic [7:0] fetch_data;    // one cycle after fetch_valid

	modport scanner (output fetch_valid, fetch_addr, fetch_bit);
	modport mem (input fetch_valid, fetch_addr, output fetch_data);
	modport colorizer (input fetch_valid, fetch_bit, fetch_data);
endinterface

`default_nettype wire

// File: common/video_pkg.sv
`default_nettype none

`include "video_defines.svh"

package video_pkg;

	// which block a bus cycle lands in
	typedef enum logic [1:0] {
		REGION_NONE = 2'd0,
		REGION_FB   = 2'd1,
		REGION_REG  = 2'd2
	} region_e;

	// bus handshake states, ACK and ERR wait for as_l to rise
	typedef enum logic [1:0] {
		BUS_IDLE   = 2'd0,
		BUS_ACCESS = 2'd1,
		BUS_ACK    = 2'd2,
		BUS_ERR    = 2'd3
	} bus_state_e;

	typedef logic [7:0] colour_t;                   // rgb332
	typedef logic [`FB_ADDR_W-1:0] fb_addr_t;       // byte address in frame buffer
	typedef logic [7:0] pix_x_t;                    // column 0..255
	typedef logic [7:0] pix_y_t;                    // row 0..223

endpackage

`default_nettype wire

// File: common/video_defines.svh
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// bus address map
`define FB_BASE        32'h00F0_0000
`define REG_BASE       32'h00F1_0000
`define FB_ADDR_W      13

// arcade screen, one bit per pixel
`define SCREEN_W       256
`define SCREEN_H       224
`define BYTES_PER_ROW  32

// credits held by the display side out of reset
`define CREDIT_DEPTH   4

// register offsets inside the register block
`define REG_CTRL       0
`define REG_FG         2
`define REG_BG         4

`endif
